/* hw/rvPkg.sv */
package rvPkg;

    // data path and address width
    localparam int xlen     = 32;
    localparam int memWords = 256;             // unified memory depth in words
    localparam int memAw    = $clog2(memWords); // word address bits, 8 here

    // major opcodes from instr[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRtype  = 7'b0110011,
        opItype  = 7'b0010011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opSystem = 7'b1110011   // only ebreak is expected here
    } opcodeE;

    // alu operations, same codes as the single-cycle alu
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluOpE;

    typedef enum logic [1:0] {immI, immS, immB, immJ} immSrcE;

    // alu input selects
    typedef enum logic [1:0] {srcAPc, srcAOldPc, srcARs1} srcAE;
    typedef enum logic [1:0] {srcBRs2, srcBImm, srcBFour} srcBE;

    // what drives the result bus
    typedef enum logic [1:0] {resAluOut, resData, resAluResult} resultSrcE;

    // main fsm states
    typedef enum logic [3:0] {
        sIdle, sFetch, sDecode,
        sMemAdr, sMemRead, sMemWB, sMemWrite,
        sExecuteR, sExecuteI, sAluWB,
        sBeq, sJal, sHalt
    } stateE;

endpackage

/* hw/ctrlIf.sv */
`timescale 1ns/1ps

interface ctrlIf;

    // enables and strobes from the fsm
    logic pcWrite;
    logic adrSrc;       // 0 = pc, 1 = result bus
    logic memWrite;     // also goes to memory
    logic irWrite;
    logic regWrite;
    logic pcClear;      // start of run, pc back to 0

    // mux selects and alu op
    rvPkg::resultSrcE resultSrc;
    rvPkg::aluOpE     aluControl;
    rvPkg::srcAE      aluSrcA;
    rvPkg::srcBE      aluSrcB;
    rvPkg::immSrcE    immSrc;

    // decoded fields back from the datapath
    rvPkg::opcodeE opcode;
    logic [2:0]    funct3;
    logic          funct7b5;
    logic          zero;

    modport controller (
        output pcWrite, adrSrc, memWrite, irWrite, regWrite, pcClear,
        output resultSrc, aluControl, aluSrcA, aluSrcB, immSrc,
        input  opcode, funct3, funct7b5, zero
    );

    modport datapath (
        input  pcWrite, adrSrc, irWrite, regWrite, pcClear,
        input  resultSrc, aluControl, aluSrcA, aluSrcB, immSrc,
        output opcode, funct3, funct7b5, zero
    );

endinterface

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [rvPkg::xlen-1:0] srcA,
    input  logic [rvPkg::xlen-1:0] srcB,
    input  rvPkg::aluOpE           aluControl,
    output logic [rvPkg::xlen-1:0] aluResult,
    output logic                   zero        // for beq
);

    logic lessThan;

    // signed compare for slt and slti
    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluControl)
            rvPkg::aluAdd: aluResult = srcA + srcB;
            rvPkg::aluSub: aluResult = srcA - srcB;
            rvPkg::aluAnd: aluResult = srcA & srcB;
            rvPkg::aluOr:  aluResult = srcA | srcB;
            rvPkg::aluSlt: aluResult = {{(rvPkg::xlen-1){1'b0}}, lessThan};
            default:       aluResult = srcA + srcB;   // unused codes just add
        endcase
    end

    // beq uses sub, so equal operands give zero
    assign zero = (aluResult == '0);

endmodule

/* hw/immExtend.sv */
`timescale 1ns/1ps

module immExtend (
    input  logic [31:7]            instr,
    input  rvPkg::immSrcE          immSrc,
    output logic [rvPkg::xlen-1:0] immExt
);

    always_comb begin
        case (immSrc)
            // addi, lw, etc
            rvPkg::immI: immExt = {{20{instr[31]}}, instr[31:20]};
            // sw, offset split over two fields
            rvPkg::immS: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // beq, halfword offset so bit 0 is always 0
            rvPkg::immB: immExt = {{20{instr[31]}}, instr[7], instr[30:25],
                                   instr[11:8], 1'b0};
            // jal, 21-bit offset
            rvPkg::immJ: immExt = {{12{instr[31]}}, instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
            default:     immExt = '0;
        endcase
    end

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  logic                   we,
    input  logic [4:0]             a1,     // rs1
    input  logic [4:0]             a2,     // rs2
    input  logic [4:0]             a3,     // rd
    input  logic [rvPkg::xlen-1:0] wd3,
    output logic [rvPkg::xlen-1:0] rd1,
    output logic [rvPkg::xlen-1:0] rd2
);

    logic [rvPkg::xlen-1:0] regs [32];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we && (a3 != 5'd0)) regs[a3] <= wd3;
    end

    // reads are combinational, x0 forced to zero
    assign rd1 = (a1 == 5'd0) ? '0 : regs[a1];
    assign rd2 = (a2 == 5'd0) ? '0 : regs[a2];

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                   clk,
    input  logic                   reset,
    ctrlIf.datapath                ctrl,
    input  logic [rvPkg::xlen-1:0] readData,    // from unified memory
    output logic [rvPkg::xlen-1:0] memAdr,
    output logic [rvPkg::xlen-1:0] writeData    // rs2 register, goes to memory
);

    logic [rvPkg::xlen-1:0] pc;
    logic [rvPkg::xlen-1:0] oldPc;      // pc of the instruction in instr
    logic [rvPkg::xlen-1:0] instr;
    logic [rvPkg::xlen-1:0] data;       // memory read register
    logic [rvPkg::xlen-1:0] a;          // rs1 register
    logic [rvPkg::xlen-1:0] aluOut;
    logic [rvPkg::xlen-1:0] rd1, rd2;
    logic [rvPkg::xlen-1:0] immExt;
    logic [rvPkg::xlen-1:0] srcA, srcB;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [rvPkg::xlen-1:0] result;     // shared result bus

    // pc, cleared at start of every run
    always_ff @(posedge clk) begin
        if (reset || ctrl.pcClear) pc <= '0;
        else if (ctrl.pcWrite)     pc <= result;
    end

    // instruction and its pc latched together in fetch
    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            oldPc <= pc;
            instr <= readData;
        end
    end

    // non-architectural regs, loaded every cycle
    always_ff @(posedge clk) begin
        data      <= readData;
        a         <= rd1;
        writeData <= rd2;
        aluOut    <= aluResult;
    end

    assign memAdr = ctrl.adrSrc ? result : pc;   // data access vs fetch

    // fields the controller decodes
    assign ctrl.opcode   = rvPkg::opcodeE'(instr[6:0]);
    assign ctrl.funct3   = instr[14:12];
    assign ctrl.funct7b5 = instr[30];

    regFile rf (
        .clk (clk),
        .we  (ctrl.regWrite),
        .a1  (instr[19:15]),
        .a2  (instr[24:20]),
        .a3  (instr[11:7]),
        .wd3 (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    immExtend ext (
        .instr  (instr[31:7]),
        .immSrc (ctrl.immSrc),
        .immExt (immExt)
    );

    always_comb begin
        case (ctrl.aluSrcA)
            rvPkg::srcAPc:    srcA = pc;
            rvPkg::srcAOldPc: srcA = oldPc;     // branch target, jal link
            default:          srcA = a;
        endcase
        case (ctrl.aluSrcB)
            rvPkg::srcBRs2:  srcB = writeData;
            rvPkg::srcBImm:  srcB = immExt;
            default:         srcB = 32'd4;      // next sequential pc
        endcase
    end

    alu alu (
        .srcA       (srcA),
        .srcB       (srcB),
        .aluControl (ctrl.aluControl),
        .aluResult  (aluResult),
        .zero       (ctrl.zero)
    );

    always_comb begin
        case (ctrl.resultSrc)
            rvPkg::resAluOut: result = aluOut;
            rvPkg::resData:   result = data;
            default:          result = aluResult;   // pc+4 straight in fetch
        endcase
    end

endmodule

/* hw/controller.sv */
`timescale 1ns/1ps

module controller (
    input  logic        clk,
    input  logic        reset,
    input  logic        req,    // host start request
    output logic        ack,    // run done
    ctrlIf.controller   ctrl
);

    rvPkg::stateE state, stateNext;
    rvPkg::aluOpE aluDecoded;

    always_ff @(posedge clk) begin
        if (reset) state <= rvPkg::sIdle;
        else       state <= stateNext;
    end

    // alu decoder for r-type and i-type execute
    always_comb begin
        case (ctrl.funct3)
            3'b000: begin
                // sub only for r-type, addi has imm bits in funct7 slot
                if (ctrl.opcode == rvPkg::opRtype && ctrl.funct7b5)
                    aluDecoded = rvPkg::aluSub;
                else
                    aluDecoded = rvPkg::aluAdd;
            end
            3'b010:  aluDecoded = rvPkg::aluSlt;
            3'b110:  aluDecoded = rvPkg::aluOr;
            3'b111:  aluDecoded = rvPkg::aluAnd;
            default: aluDecoded = rvPkg::aluAdd;
        endcase
    end

    always_comb begin
        // defaults, nothing written
        stateNext       = state;
        ctrl.pcWrite    = 1'b0;
        ctrl.adrSrc     = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.irWrite    = 1'b0;
        ctrl.regWrite   = 1'b0;
        ctrl.pcClear    = 1'b0;
        ctrl.resultSrc  = rvPkg::resAluOut;
        ctrl.aluControl = rvPkg::aluAdd;
        ctrl.aluSrcA    = rvPkg::srcARs1;
        ctrl.aluSrcB    = rvPkg::srcBImm;
        ctrl.immSrc     = rvPkg::immI;

        case (state)
            rvPkg::sIdle: begin
                if (req) begin
                    ctrl.pcClear = 1'b1;     // run starts at address 0
                    stateNext    = rvPkg::sFetch;
                end
            end
            rvPkg::sFetch: begin
                // instr <= mem[pc], pc <= pc + 4
                ctrl.irWrite   = 1'b1;
                ctrl.pcWrite   = 1'b1;
                ctrl.aluSrcA   = rvPkg::srcAPc;
                ctrl.aluSrcB   = rvPkg::srcBFour;
                ctrl.resultSrc = rvPkg::resAluResult;
                stateNext      = rvPkg::sDecode;
            end
            rvPkg::sDecode: begin
                // precompute oldPc + imm for beq/jal
                ctrl.aluSrcA = rvPkg::srcAOldPc;
                ctrl.immSrc  = (ctrl.opcode == rvPkg::opJal) ? rvPkg::immJ : rvPkg::immB;
                case (ctrl.opcode)
                    rvPkg::opLoad,
                    rvPkg::opStore:  stateNext = rvPkg::sMemAdr;
                    rvPkg::opRtype:  stateNext = rvPkg::sExecuteR;
                    rvPkg::opItype:  stateNext = rvPkg::sExecuteI;
                    rvPkg::opBranch: stateNext = rvPkg::sBeq;
                    rvPkg::opJal:    stateNext = rvPkg::sJal;
                    default:         stateNext = rvPkg::sHalt;  // ebreak, or anything unknown
                endcase
            end
            rvPkg::sMemAdr: begin
                ctrl.immSrc = (ctrl.opcode == rvPkg::opStore) ? rvPkg::immS : rvPkg::immI;
                stateNext   = (ctrl.opcode == rvPkg::opLoad) ? rvPkg::sMemRead
                                                            : rvPkg::sMemWrite;
            end
            rvPkg::sMemRead: begin
                ctrl.adrSrc = 1'b1;          // address from aluOut
                stateNext   = rvPkg::sMemWB;
            end
            rvPkg::sMemWB: begin
                ctrl.resultSrc = rvPkg::resData;
                ctrl.regWrite  = 1'b1;
                stateNext      = rvPkg::sFetch;
            end
            rvPkg::sMemWrite: begin
                ctrl.adrSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                stateNext     = rvPkg::sFetch;
            end
            rvPkg::sExecuteR: begin
                ctrl.aluSrcB    = rvPkg::srcBRs2;
                ctrl.aluControl = aluDecoded;
                stateNext       = rvPkg::sAluWB;
            end
            rvPkg::sExecuteI: begin
                ctrl.aluControl = aluDecoded;
                stateNext       = rvPkg::sAluWB;
            end
            rvPkg::sAluWB: begin
                ctrl.regWrite = 1'b1;        // aluOut into rd
                stateNext     = rvPkg::sFetch;
            end
            rvPkg::sBeq: begin
                ctrl.aluSrcB    = rvPkg::srcBRs2;
                ctrl.aluControl = rvPkg::aluSub;
                ctrl.pcWrite    = ctrl.zero;    // taken: pc <= target in aluOut
                stateNext       = rvPkg::sFetch;
            end
            rvPkg::sJal: begin
                // pc <= target, alu makes oldPc + 4 for the link
                ctrl.aluSrcA = rvPkg::srcAOldPc;
                ctrl.aluSrcB = rvPkg::srcBFour;
                ctrl.pcWrite = 1'b1;
                stateNext    = rvPkg::sAluWB;
            end
            rvPkg::sHalt: begin
                if (!req) stateNext = rvPkg::sIdle;   // ack drops next cycle
            end
            default: stateNext = rvPkg::sIdle;
        endcase
    end

    assign ack = (state == rvPkg::sHalt);

endmodule

/* hw/unifiedMem.sv */
`timescale 1ns/1ps

module unifiedMem (
    input  logic                    clk,
    input  logic                    we,         // core store
    input  logic [rvPkg::xlen-1:0]  adr,        // byte address from core
    input  logic [rvPkg::xlen-1:0]  wd,
    input  logic                    loadEn,     // host program load
    input  logic [rvPkg::memAw-1:0] loadAddr,   // word address
    input  logic [rvPkg::xlen-1:0]  loadData,
    input  logic [rvPkg::memAw-1:0] hostAddr,   // word address, readback
    output logic [rvPkg::xlen-1:0]  rd,
    output logic [rvPkg::xlen-1:0]  hostData
);

    logic [rvPkg::xlen-1:0] mem [rvPkg::memWords];
    logic [rvPkg::memAw-1:0] wordAdr;

    // word aligned only, upper bits wrap
    assign wordAdr = adr[rvPkg::memAw+1:2];

    // host load wins over a core store
    always_ff @(posedge clk) begin
        if (loadEn)  mem[loadAddr] <= loadData;
        else if (we) mem[wordAdr]  <= wd;
    end

    assign rd       = mem[wordAdr];
    assign hostData = mem[hostAddr];

endmodule

/* hw/multicycleCpu.sv */
`timescale 1ns/1ps

module multicycleCpu (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req,
    output logic                    ack,
    // host load port
    input  logic                    loadEn,
    input  logic [rvPkg::memAw-1:0] loadAddr,
    input  logic [rvPkg::xlen-1:0]  loadData,
    // host readback port
    input  logic [rvPkg::memAw-1:0] hostAddr,
    output logic [rvPkg::xlen-1:0]  hostData
);

    logic [rvPkg::xlen-1:0] memAdr;
    logic [rvPkg::xlen-1:0] writeData;
    logic [rvPkg::xlen-1:0] readData;

    ctrlIf cIf ();

    controller ctrlUnit (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .ack   (ack),
        .ctrl  (cIf.controller)
    );

    datapath dp (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (cIf.datapath),
        .readData  (readData),
        .memAdr    (memAdr),
        .writeData (writeData)
    );

    unifiedMem mem (
        .clk      (clk),
        .we       (cIf.memWrite),    // straight from the fsm
        .adr      (memAdr),
        .wd       (writeData),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .hostAddr (hostAddr),
        .rd       (readData),
        .hostData (hostData)
    );

endmodule

/* dv/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    // 4 ns period, first rising edge at 2 ns
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // sync reset, high over the first 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* dv/cpu_properties.sv */
`timescale 1ns/1ps

module cpuProperties (
    input logic         clk,
    input logic         reset,
    input logic         req,
    input logic         ack,
    input rvPkg::stateE state,
    input logic         pcWrite,
    input logic         irWrite,
    input logic         regWrite,
    input logic         memWrite
);

    int assertFails = 0;    // count of failed assertions

    // ack only comes up while the host holds req
    ackNeedsReq: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
        else begin
            $error("ack rose while req was low");
            assertFails++;
        end

    // ack drops one cycle after req was seen low
    ackFallsAfterReq: assert property (@(posedge clk) disable iff (reset)
        $fell(ack) |-> !$past(req))
        else begin
            $error("ack fell while req was still high");
            assertFails++;
        end

    // a state writes at most one of rf, memory, ir
    oneWriteEnable: assert property (@(posedge clk) disable iff (reset)
        $onehot0({regWrite, memWrite, irWrite}))
        else begin
            $error("more than one of regWrite, memWrite, irWrite high");
            assertFails++;
        end

    // idle does nothing until req
    idleQuiet: assert property (@(posedge clk) disable iff (reset)
        (state == rvPkg::sIdle) |-> !(pcWrite || irWrite || regWrite || memWrite))
        else begin
            $error("write enable high in idle");
            assertFails++;
        end

endmodule

bind controller cpuProperties props (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .ack      (ack),
    .state    (state),
    .pcWrite  (ctrl.pcWrite),
    .irWrite  (ctrl.irWrite),
    .regWrite (ctrl.regWrite),
    .memWrite (ctrl.memWrite)
);

/* dv/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;

    logic                    clk;
    logic                    reset;
    logic                    req;
    logic                    ack;
    logic                    loadEn;
    logic [rvPkg::memAw-1:0] loadAddr;
    logic [rvPkg::xlen-1:0]  loadData;
    logic [rvPkg::memAw-1:0] hostAddr;
    logic [rvPkg::xlen-1:0]  hostData;

    // program from word 0 with operands at word 32 (0x80) and results at word 40 (0xa0)
    logic [rvPkg::xlen-1:0] image [64];
    int mismatchCount = 0;
    int otherErrors   = 0;

    clockGen clkGen (.clk(clk), .reset(reset));

    multicycleCpu DUT (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .ack      (ack),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .hostAddr (hostAddr),
        .hostData (hostData)
    );

    // rv32i encoders
    function automatic logic [31:0] rType(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] lwAt(int rd, int off);
        return iType(off, 0, 2, rd, 7'h03);     // base x0
    endfunction

    function automatic logic [31:0] swAt(int rs2, int off);
        return {off[11:5], rs2[4:0], 5'd0, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beqTo(int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jalTo(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] haltInstr();
        return 32'h0010_0073;   // ebreak
    endfunction

    function automatic logic [31:0] fillWord(int addr);
        return {16'hdead, 8'h00, addr[7:0]};
    endfunction

    // worst case 5 cycles per instruction plus idle and halt entry
    function automatic int runBudget(int instrs);
        return 5 * instrs + 8;
    endfunction

    // load, run, handshake and up to 16 readbacks
    function automatic int testCycles(int instrs);
        return 66 + runBudget(instrs) + 10 + 2 * 16;
    endfunction

    function automatic int watchdogCycles();
        return 16 + testCycles(15) + testCycles(18) + testCycles(12) + testCycles(8)
               + testCycles(3) + testCycles(4) + 200;
    endfunction

    task automatic checkWord(input string name, input logic [rvPkg::xlen-1:0] expected,
                             input logic [rvPkg::xlen-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic checkAck(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s ack: expected %b, actual %b", name, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic fillImage();
        for (int i = 0; i < 64; i++) image[i] = fillWord(i);
    endtask

    task automatic loadImage();
        for (int i = 0; i < 64; i++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= i[rvPkg::memAw-1:0];
            loadData <= image[i];
        end
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    task automatic checkResult(input string name, input int word,
                               input logic [rvPkg::xlen-1:0] expected);
        @(posedge clk);
        hostAddr <= word[rvPkg::memAw-1:0];
        @(negedge clk);     // combinational hostData has settled by the falling edge
        checkWord($sformatf("%s word %0d", name, word), expected, hostData);
    endtask

    // full four-phase handshake around one run
    task automatic runProgram(input string name, input int instrs);
        int cycles;
        cycles = 0;
        @(negedge clk);
        checkAck(name, 1'b0, ack);      // nothing before req
        @(posedge clk);
        req <= 1'b1;
        @(negedge clk);
        while (!ack && cycles < runBudget(instrs)) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack) begin
            $display("%s: ack did not rise within %0d cycles", name, runBudget(instrs));
            otherErrors++;
            @(posedge clk);
            req <= 1'b0;
        end else begin
            repeat (3) begin
                @(negedge clk);
                checkAck(name, 1'b1, ack);  // held while req is up
            end
            @(posedge clk);
            req <= 1'b0;
            @(negedge clk);
            checkAck(name, 1'b1, ack);      // core has not seen req low yet
            @(negedge clk);
            checkAck(name, 1'b0, ack);
        end
    endtask

    task automatic arithTest();
        logic [rvPkg::xlen-1:0] a, b;
        a = $urandom & 32'h7fff_ffff;   // positive
        b = $urandom | 32'h8000_0000;   // negative so slt differs by order
        fillImage();
        image[32] = a;
        image[33] = b;
        image[0]  = lwAt(1, 128);
        image[1]  = lwAt(2, 132);
        image[2]  = rType(0, 2, 1, 0, 3);       // add x3
        image[3]  = swAt(3, 160);
        image[4]  = rType(32, 2, 1, 0, 4);      // sub x4
        image[5]  = swAt(4, 164);
        image[6]  = rType(0, 2, 1, 7, 5);       // and x5
        image[7]  = swAt(5, 168);
        image[8]  = rType(0, 2, 1, 6, 6);       // or x6
        image[9]  = swAt(6, 172);
        image[10] = rType(0, 2, 1, 2, 7);       // slt x7, x1, x2
        image[11] = swAt(7, 176);
        image[12] = rType(0, 1, 2, 2, 8);       // slt x8, x2, x1
        image[13] = swAt(8, 180);
        image[14] = haltInstr();
        loadImage();
        runProgram("arith", 15);
        checkResult("arith", 40, a + b);
        checkResult("arith", 41, a - b);
        checkResult("arith", 42, a & b);
        checkResult("arith", 43, a | b);
        checkResult("arith", 44, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        checkResult("arith", 45, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    endtask

    task automatic immediateTest();
        logic [rvPkg::xlen-1:0] a, immX, expected;
        int imms [8];
        int f3s [8];
        a    = $urandom;
        imms = '{-5, 1234, -16, 2047, -2048, 240, -1, 100};
        f3s  = '{0, 0, 7, 7, 6, 6, 2, 2};      // addi addi andi andi ori ori slti slti
        fillImage();
        image[32] = a;
        image[0]  = lwAt(1, 128);
        for (int k = 0; k < 8; k++) begin
            image[1 + 2 * k] = iType(imms[k], 1, f3s[k], 2 + k, 7'h13);
            image[2 + 2 * k] = swAt(2 + k, 160 + 4 * k);
        end
        image[17] = haltInstr();
        loadImage();
        runProgram("imm", 18);
        for (int k = 0; k < 8; k++) begin
            immX = imms[k];     // every immediate fits in 12 signed bits
            case (f3s[k])
                0:       expected = a + immX;
                7:       expected = a & immX;
                6:       expected = a | immX;
                default: expected = ($signed(a) < $signed(immX)) ? 32'd1 : 32'd0;
            endcase
            checkResult($sformatf("imm[%0d]", k), 40 + k, expected);
        end
    endtask

    task automatic branchJumpTest();
        logic [rvPkg::xlen-1:0] v, w;
        v = $urandom;
        w = v ^ ($urandom | 32'd1);     // never equal to v
        fillImage();
        image[32] = v;
        image[33] = w;
        image[0]  = lwAt(1, 128);
        image[1]  = lwAt(2, 128);               // x2 == x1
        image[2]  = lwAt(3, 132);
        image[3]  = iType(85, 0, 0, 4, 7'h13);  // marker 0x55
        image[4]  = beqTo(1, 2, 8);             // taken
        image[5]  = swAt(4, 160);
        image[6]  = beqTo(1, 3, 8);             // not taken
        image[7]  = swAt(4, 164);
        image[8]  = jalTo(5, 8);                // skips word 9
        image[9]  = swAt(4, 168);
        image[10] = swAt(5, 172);               // link value
        image[11] = haltInstr();
        loadImage();
        runProgram("branch", 12);
        checkResult("branch", 40, fillWord(40));    // store skipped
        checkResult("branch", 41, 32'h55);
        checkResult("branch", 42, fillWord(42));
        checkResult("branch", 43, 8 * 4 + 4);       // jal at word 8
    endtask

    task automatic zeroRegTest();
        logic [rvPkg::xlen-1:0] v;
        v = $urandom | 32'd1;
        fillImage();
        image[32] = v;
        image[0]  = lwAt(1, 128);
        image[1]  = rType(0, 1, 1, 0, 0);       // add x0, x1, x1
        image[2]  = iType(5, 1, 0, 0, 7'h13);   // addi x0, x1, 5
        image[3]  = swAt(0, 160);
        image[4]  = lwAt(0, 128);
        image[5]  = swAt(0, 164);
        image[6]  = swAt(1, 168);
        image[7]  = haltInstr();
        loadImage();
        runProgram("x0", 8);
        checkResult("x0", 40, 32'd0);
        checkResult("x0", 41, 32'd0);
        checkResult("x0", 42, v);
    endtask

    task automatic handshakeTest();
        int k1, k2;
        k1 = $urandom % 2048;
        k2 = $urandom % 1024;
        repeat (4) begin
            @(negedge clk);
            checkAck("handshake idle", 1'b0, ack);
        end
        fillImage();
        image[0] = iType(k1, 0, 0, 1, 7'h13);
        image[1] = swAt(1, 160);
        image[2] = haltInstr();
        loadImage();
        runProgram("handshake A", 3);
        checkResult("handshake A", 40, k1);
        // second program only works if the pc restarts at 0
        fillImage();
        image[0] = iType(k2, 0, 0, 2, 7'h13);
        image[1] = iType(k2, 2, 0, 2, 7'h13);
        image[2] = swAt(2, 164);
        image[3] = haltInstr();
        loadImage();
        runProgram("handshake B", 4);
        checkResult("handshake B", 40, fillWord(40));
        checkResult("handshake B", 41, k2 * 2);
    endtask

    initial begin : watchdog
        int limit;
        limit = watchdogCycles();
        #(limit * 4);
        $display("timeout: tests still running after %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'hba54));
        req      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        hostAddr = '0;
        while (reset !== 1'b0) @(negedge clk);
        arithTest();
        immediateTest();
        branchJumpTest();
        zeroRegTest();
        handshakeTest();
        $display("done: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatchCount, otherErrors, DUT.ctrlUnit.props.assertFails);
        if (mismatchCount + otherErrors + DUT.ctrlUnit.props.assertFails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* all.f */
hw/rvPkg.sv
hw/ctrlIf.sv
hw/alu.sv
hw/immExtend.sv
hw/regFile.sv
hw/datapath.sv
hw/controller.sv
hw/unifiedMem.sv
hw/multicycleCpu.sv
dv/clockGen.sv
dv/cpu_properties.sv
dv/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASSLINE  ?= *** PASSED ***
VFLAGS    ?= --binary --timing --assert -j 0
SIMARGS   ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with verilator, run it, check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJDIR LOG VFLAGS SIMARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(SIMARGS) 2>&1 | tee $(LOG)
	@grep -qxF -- '$(PASSLINE)' $(LOG) && echo "test ok" || \
		(echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
